// ==== Bender.yml ====
package:
  name: event_logger

sources:
  - design/logger_pkg.sv
  - design/logger_regs_pkg.sv
  - design/logger_regs.sv
  - design/msg_channel.sv
  - design/pulse_channel.sv
  - design/event_timestamper.sv
  - design/record_arbiter.sv
  - design/event_logger.sv
  - target: test
    files:
      - dv/tb_event_logger.sv

// ==== design/event_logger.sv ====
//////////////////////////////////////////////////
// event logger top
// register block, message and pulse channels,
// timestamper and record arbiter on one clock
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module event_logger
    import logger_pkg::*;
    import logger_regs_pkg::*;
#(
    parameter int N_GPIO = 10    // at most 16 pins
) (
    input  logic              xclk,
    input  logic              config_rst,
    input  logic              i_cmd_valid,
    input  reg_addr_t         i_cmd_addr,
    input  cfg_data_t         i_cmd_data,
    input  logic [N_GPIO-1:0] i_gpio,
    input  logic              i_log_ready,
    output logic              o_log_valid,
    output word_t             o_log_data
);

    gpio_sel_t         msg_sel;
    gpio_sel_t         pulse_sel;
    logic              msg_inv;
    logic              msg_en;
    logic              pulse_en;
    logic              msg_we;
    logic [1:0]        msg_waddr;
    word_t             msg_wdata;
    word_t             msg_data;
    logic              msg_next;
    logic [N_CHAN-1:0] ts_req;      // indexed by channel number
    logic [N_CHAN-1:0] ts_ack;
    logic [N_CHAN-1:0] pending;
    logic [N_CHAN-1:0] rdy;
    logic [N_CHAN-1:0] done;
    chan_t             ts_sel;
    time_t             ts_time;

    logger_regs u_logger_regs (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .o_msg_sel   (msg_sel),
        .o_pulse_sel (pulse_sel),
        .o_msg_inv   (msg_inv),
        .o_msg_en    (msg_en),
        .o_pulse_en  (pulse_en),
        .o_msg_we    (msg_we),
        .o_msg_waddr (msg_waddr),
        .o_msg_wdata (msg_wdata)
    );

    msg_channel #(.N_GPIO(N_GPIO)) u_msg_channel (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_gpio     (i_gpio),
        .i_sel      (msg_sel),
        .i_inv      (msg_inv),
        .i_en       (msg_en),
        .i_we       (msg_we),
        .i_waddr    (msg_waddr),
        .i_wdata    (msg_wdata),
        .i_next     (msg_next),
        .i_done     (done[CH_MSG]),
        .o_ts_req   (ts_req[CH_MSG]),
        .o_rdy      (rdy[CH_MSG]),
        .o_data     (msg_data)
    );

    pulse_channel #(.N_GPIO(N_GPIO)) u_pulse_channel (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_gpio     (i_gpio),
        .i_sel      (pulse_sel),
        .i_en       (pulse_en),
        .i_done     (done[CH_PULSE]),
        .o_ts_req   (ts_req[CH_PULSE]),
        .o_rdy      (rdy[CH_PULSE])
    );

    event_timestamper u_event_timestamper (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_req      (ts_req),
        .i_ack      (ts_ack),
        .i_sel      (ts_sel),
        .o_pending  (pending),
        .o_time     (ts_time)
    );

    record_arbiter u_record_arbiter (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_rdy       (rdy),
        .i_pending   (pending),
        .i_time      (ts_time),
        .i_msg_data  (msg_data),
        .i_log_ready (i_log_ready),
        .o_sel       (ts_sel),
        .o_ack       (ts_ack),
        .o_msg_next  (msg_next),
        .o_done      (done),
        .o_log_valid (o_log_valid),
        .o_log_data  (o_log_data)
    );

endmodule

`default_nettype wire

// ==== design/event_timestamper.sv ====
//////////////////////////////////////////////////
// event logger timestamper
// free running time counter and one held latch
// per channel, released by the arbiter
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module event_timestamper
    import logger_pkg::*;
(
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [N_CHAN-1:0] i_req,
    input  logic [N_CHAN-1:0] i_ack,
    input  chan_t             i_sel,
    output logic [N_CHAN-1:0] o_pending,
    output time_t             o_time
);

    time_t time_q;             // zero in the first cycle after reset
    time_t ts_q [N_CHAN];

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            time_q    <= '0;
            o_pending <= '0;
        end else begin
            time_q <= time_q + 1'b1;
            for (int c = 0; c < N_CHAN; c++) begin
                if (i_req[c]) o_pending[c] <= 1'b1;
                else if (i_ack[c]) o_pending[c] <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        for (int c = 0; c < N_CHAN; c++) begin
            if (i_req[c]) ts_q[c] <= time_q;    // newer request overwrites
        end
    end

    assign o_time = ts_q[i_sel];

    // arbiter only releases a channel it saw stamped
    a_ack_pending: assert property (@(posedge xclk) disable iff (config_rst)
        (i_ack & ~o_pending) == '0)
        else $error("timestamp ack without a pending latch");

endmodule

`default_nettype wire

// ==== design/logger_pkg.sv ====
//////////////////////////////////////////////////
// event logger datapath definitions
// widths, record layout, channel numbers and the
// arbiter state encoding
//////////////////////////////////////////////////
`default_nettype none

package logger_pkg;

    typedef logic [15:0] word_t;     // one output or message word
    typedef logic [31:0] time_t;     // xclk cycles since reset release
    typedef logic        chan_t;     // channel number
    typedef logic [14:0] seq_t;      // record sequence count

    localparam chan_t CH_PULSE = 1'b0;  // highest priority
    localparam chan_t CH_MSG   = 1'b1;
    localparam int    N_CHAN   = 2;

    // record is header, time high, time low, then payload
    localparam int MSG_WORDS    = 4;
    localparam int RECORD_WORDS = 7;

    // pulse level must hold this long, power of two
    localparam int DENOISE_CYCLES = 16;
    // first sample of an edge to the latched time
    localparam int TS_LATENCY     = 2;

    typedef enum logic {
        IDLE,   // waiting for a ready and stamped channel
        SEND    // streaming the words of one record
    } arb_state_t;

endpackage

`default_nettype wire

// ==== design/logger_regs.sv ====
//////////////////////////////////////////////////
// event logger register block
// decodes command writes into the config register
// and registered message word write strobes
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module logger_regs
    import logger_pkg::*;
    import logger_regs_pkg::*;
(
    input  logic       xclk,
    input  logic       config_rst,
    input  logic       i_cmd_valid,
    input  reg_addr_t  i_cmd_addr,
    input  cfg_data_t  i_cmd_data,
    output gpio_sel_t  o_msg_sel,
    output gpio_sel_t  o_pulse_sel,
    output logic       o_msg_inv,
    output logic       o_msg_en,
    output logic       o_pulse_en,
    output logic       o_msg_we,
    output logic [1:0] o_msg_waddr,
    output word_t      o_msg_wdata
);

    logic [CFG_LOG_EN:0] cfg_q;    // fields 11:0 of the config word
    logic                cfg_wr;
    logic                msg_wr;

    assign cfg_wr = i_cmd_valid && (i_cmd_addr == ADDR_CONFIG);
    assign msg_wr = i_cmd_valid && (i_cmd_addr >= ADDR_MSG_BASE);  // upper half of the map

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            cfg_q    <= '0;          // everything disabled
            o_msg_we <= 1'b0;
        end else begin
            if (cfg_wr) cfg_q <= i_cmd_data[CFG_LOG_EN:0];
            o_msg_we <= msg_wr;      // one cycle behind the command
        end
    end

    always_ff @(posedge xclk) begin
        if (msg_wr) begin
            o_msg_waddr <= i_cmd_addr[1:0];               // base is 4, low bits index the word
            o_msg_wdata <= i_cmd_data[$bits(word_t)-1:0];
        end
    end

    assign o_msg_sel   = cfg_q[CFG_MSG_SEL +: $bits(gpio_sel_t)];
    assign o_pulse_sel = cfg_q[CFG_PULSE_SEL +: $bits(gpio_sel_t)];
    assign o_msg_inv   = cfg_q[CFG_MSG_INV];

    // channel enables already qualified by the logger enable
    assign o_msg_en   = cfg_q[CFG_MSG_EN] & cfg_q[CFG_LOG_EN];
    assign o_pulse_en = cfg_q[CFG_PULSE_EN] & cfg_q[CFG_LOG_EN];

    // command fields settle before the valid edge
    a_cmd_known: assert property (@(posedge xclk) disable iff (config_rst)
        i_cmd_valid |-> !$isunknown({i_cmd_addr, i_cmd_data}))
        else $error("command address or data unknown on a valid write");

endmodule

`default_nettype wire

// ==== design/logger_regs_pkg.sv ====
//////////////////////////////////////////////////
// event logger register map
// command addresses and config field positions
//////////////////////////////////////////////////
`default_nettype none

package logger_regs_pkg;

    typedef logic [2:0]  reg_addr_t;   // command address
    typedef logic [31:0] cfg_data_t;   // command data
    typedef logic [3:0]  gpio_sel_t;   // gpio index

    localparam reg_addr_t ADDR_CONFIG   = 3'd0;
    localparam reg_addr_t ADDR_MSG_BASE = 3'd4;  // 4..7 are message words 0..3

    // config register field positions
    localparam int CFG_MSG_SEL   = 0;    // 3:0 message trigger pin
    localparam int CFG_MSG_INV   = 4;    // invert the trigger
    localparam int CFG_MSG_EN    = 5;
    localparam int CFG_PULSE_SEL = 6;    // 9:6 pulse pin
    localparam int CFG_PULSE_EN  = 10;
    localparam int CFG_LOG_EN    = 11;   // master enable, topmost field

endpackage

`default_nettype wire

// ==== design/msg_channel.sv ====
//////////////////////////////////////////////////
// event logger message channel
// leading trigger edge requests the timestamp,
// trailing edge marks the software message ready
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module msg_channel
    import logger_pkg::*;
    import logger_regs_pkg::*;
#(
    parameter int N_GPIO = 10
) (
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [N_GPIO-1:0] i_gpio,
    input  gpio_sel_t         i_sel,
    input  logic              i_inv,
    input  logic              i_en,
    input  logic              i_we,
    input  logic [1:0]        i_waddr,
    input  word_t             i_wdata,
    input  logic              i_next,
    input  logic              i_done,
    output logic              o_ts_req,
    output logic              o_rdy,
    output word_t             o_data
);

    logic [N_GPIO-1:0]               gpio_s0;    // first sample
    logic [N_GPIO-1:0]               gpio_s1;
    logic [N_GPIO-1:0]               gpio_s2;    // previous synced value
    logic [2**$bits(gpio_sel_t)-1:0] cur_ext;
    logic [2**$bits(gpio_sel_t)-1:0] prev_ext;
    logic                            lead;
    logic                            trail;
    logic                            armed;      // timestamp taken, waiting for trailing edge
    word_t                           msg_mem [MSG_WORDS];
    logic [1:0]                      rd_ptr;

    // pins beyond N_GPIO read as zero
    always_comb begin
        cur_ext  = '0;
        prev_ext = '0;
        cur_ext[N_GPIO-1:0]  = gpio_s1;
        prev_ext[N_GPIO-1:0] = gpio_s2;
    end

    // select and invert after the synchroniser so a config change makes no edge
    assign lead  = (cur_ext[i_sel] ^ i_inv) & ~(prev_ext[i_sel] ^ i_inv);
    assign trail = ~(cur_ext[i_sel] ^ i_inv) & (prev_ext[i_sel] ^ i_inv);

    assign o_ts_req = i_en & lead & ~o_rdy;   // ignored while a record waits

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            gpio_s0 <= '0;
            gpio_s1 <= '0;
            gpio_s2 <= '0;
            armed   <= 1'b0;
            o_rdy   <= 1'b0;
            rd_ptr  <= '0;
        end else begin
            gpio_s0 <= i_gpio;
            gpio_s1 <= gpio_s0;
            gpio_s2 <= gpio_s1;
            if (!i_en) armed <= 1'b0;
            else if (o_ts_req) armed <= 1'b1;
            else if (trail) armed <= 1'b0;
            if (!i_en || i_done) o_rdy <= 1'b0;           // disable drops the record
            else if (trail && armed) o_rdy <= 1'b1;
            if (i_done) rd_ptr <= '0;
            else if (i_next) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge xclk) begin
        if (i_we) msg_mem[i_waddr] <= i_wdata;
    end

    assign o_data = msg_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/pulse_channel.sv ====
//////////////////////////////////////////////////
// event logger pulse channel
// de-noised rising edge of a selected gpio pin,
// logged with its timestamp only
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pulse_channel
    import logger_pkg::*;
    import logger_regs_pkg::*;
#(
    parameter int N_GPIO = 10
) (
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [N_GPIO-1:0] i_gpio,
    input  gpio_sel_t         i_sel,
    input  logic              i_en,
    input  logic              i_done,
    output logic              o_ts_req,
    output logic              o_rdy
);

    logic [N_GPIO-1:0]                  gpio_s0;
    logic [N_GPIO-1:0]                  gpio_s1;
    logic [2**$bits(gpio_sel_t)-1:0]    smp_ext;
    logic                               smp;     // synced selected pin
    logic                               level;   // de-noised level
    logic [$clog2(DENOISE_CYCLES)-1:0]  cnt;     // down-counter while smp differs
    logic                               flip;

    always_comb begin
        smp_ext = '0;
        smp_ext[N_GPIO-1:0] = gpio_s1;
    end

    assign smp  = smp_ext[i_sel];
    assign flip = (smp != level) && (cnt == '0);   // new level held long enough

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            gpio_s0  <= '0;
            gpio_s1  <= '0;
            level    <= 1'b0;
            cnt      <= '1;
            o_ts_req <= 1'b0;
            o_rdy    <= 1'b0;
        end else begin
            gpio_s0 <= i_gpio;
            gpio_s1 <= gpio_s0;
            if (smp == level) cnt <= '1;                  // all ones is DENOISE_CYCLES-1
            else if (cnt != '0) cnt <= cnt - 1'b1;
            if (flip) level <= smp;
            o_ts_req <= i_en && flip && smp && !o_rdy;    // rising edges only
            if (!i_en || i_done) o_rdy <= 1'b0;
            else if (flip && smp) o_rdy <= 1'b1;          // with the request, no payload
        end
    end

endmodule

`default_nettype wire

// ==== design/record_arbiter.sv ====
//////////////////////////////////////////////////
// event logger record arbiter
// picks a ready, stamped channel and streams its
// 7-word record over a valid/ready output
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module record_arbiter
    import logger_pkg::*;
(
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [N_CHAN-1:0] i_rdy,
    input  logic [N_CHAN-1:0] i_pending,
    input  time_t             i_time,
    input  word_t             i_msg_data,
    input  logic              i_log_ready,
    output chan_t             o_sel,
    output logic [N_CHAN-1:0] o_ack,
    output logic              o_msg_next,
    output logic [N_CHAN-1:0] o_done,
    output logic              o_log_valid,
    output word_t             o_log_data
);

    arb_state_t                      state;
    logic [N_CHAN-1:0]               cand;
    logic                            grant_any;
    chan_t                           grant;
    chan_t                           chan_q;     // channel being sent
    logic [$clog2(RECORD_WORDS)-1:0] wcnt;       // index of the word on the output
    seq_t                            seq_q;
    logic                            accept;
    logic                            last;
    word_t                           next_word;

    assign cand   = i_rdy & i_pending;
    assign accept = o_log_valid & i_log_ready;
    assign last   = (wcnt == RECORD_WORDS - 1);
    assign o_sel  = chan_q;

    // lowest channel number wins
    always_comb begin
        grant_any = 1'b0;
        grant     = CH_PULSE;
        for (int c = N_CHAN - 1; c >= 0; c--) begin
            if (cand[c]) begin
                grant_any = 1'b1;
                grant     = chan_t'(c);
            end
        end
    end

    // word that follows the one being accepted
    always_comb begin
        case (wcnt)
            3'd0:    next_word = i_time[31:16];
            3'd1:    next_word = i_time[15:0];
            default: next_word = (chan_q == CH_MSG) ? i_msg_data : '0;  // pulse payload is zero
        endcase
    end

    assign o_msg_next = accept && !last && (wcnt >= 3'd2) && (chan_q == CH_MSG);

    // release the latch and the channel as the last word goes out
    always_comb begin
        o_done = '0;
        if (accept && last) o_done[chan_q] = 1'b1;
    end
    assign o_ack = o_done;

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            state       <= IDLE;
            o_log_valid <= 1'b0;
            chan_q      <= CH_PULSE;
            wcnt        <= '0;
            seq_q       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_any) begin
                        state       <= SEND;
                        o_log_valid <= 1'b1;    // header valid next cycle
                        chan_q      <= grant;
                        wcnt        <= '0;
                    end
                end
                SEND: begin
                    if (accept) begin
                        if (last) begin
                            state       <= IDLE;
                            o_log_valid <= 1'b0;
                            seq_q       <= seq_q + 1'b1;
                        end else begin
                            wcnt <= wcnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (state == IDLE) o_log_data <= {grant, seq_q};       // header, channel in bit 15
        else if (accept && !last) o_log_data <= next_word;     // held under back-pressure
    end

    a_hold: assert property (@(posedge xclk) disable iff (config_rst)
        o_log_valid && !i_log_ready |=> o_log_valid && $stable(o_log_data))
        else $error("log word changed under back-pressure");

endmodule

`default_nettype wire

// ==== dv/tb_event_logger.sv ====
//////////////////////////////////////////////////
// event logger testbench
// drives commands and gpio events, predicts each
// record and checks the 16-bit log stream
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_event_logger
    import logger_pkg::*;
    import logger_regs_pkg::*;
();

    localparam int N_GPIO          = 10;
    localparam int CLK_PERIOD      = 20;
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 800;   // generous bound per behaviour
    localparam int MSG_PIN         = 3;
    localparam int INV_PIN         = 7;
    localparam int PULSE_PIN       = 5;

    typedef logic [RECORD_WORDS*$bits(word_t)-1:0] rec_t;   // word 0 in the top bits

    logic              xclk;
    logic              config_rst;
    logic              i_cmd_valid;
    reg_addr_t         i_cmd_addr;
    cfg_data_t         i_cmd_data;
    logic [N_GPIO-1:0] i_gpio;
    logic              i_log_ready;
    logic              o_log_valid;
    word_t             o_log_data;

    time_t       cyc;              // tracks the time counter, 0 at reset release
    word_t       exp_q[$];         // expected log words in order
    seq_t        exp_seq;
    logic [63:0] msg_payload;      // word 0 in the top bits
    logic        rand_ready;
    int          errors;
    int          checks;
    int unsigned seed_val;

    event_logger #(.N_GPIO(N_GPIO)) u_event_logger (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .i_gpio      (i_gpio),
        .i_log_ready (i_log_ready),
        .o_log_valid (o_log_valid),
        .o_log_data  (o_log_data)
    );

    initial begin
        xclk = 1'b0;
        forever #(CLK_PERIOD/2) xclk = ~xclk;
    end

    always @(posedge xclk) begin
        if (config_rst) cyc <= '0;
        else cyc <= cyc + 1'b1;
    end

    // expected record from the layout: header, time high, time low, payload
    function automatic rec_t build_record(chan_t ch, seq_t seq, time_t ts, logic [63:0] pay);
        rec_t r;
        r = {ch, seq, ts[31:16], ts[15:0], pay};
        return r;
    endfunction

    function automatic cfg_data_t config_word(gpio_sel_t msel, logic inv, logic men,
                                              gpio_sel_t psel, logic pen, logic len);
        cfg_data_t w;
        w = '0;
        w[CFG_MSG_SEL +: $bits(gpio_sel_t)]   = msel;
        w[CFG_MSG_INV]                        = inv;
        w[CFG_MSG_EN]                         = men;
        w[CFG_PULSE_SEL +: $bits(gpio_sel_t)] = psel;
        w[CFG_PULSE_EN]                       = pen;
        w[CFG_LOG_EN]                         = len;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic push_record(input chan_t ch, input time_t ts, input logic [63:0] pay);
        rec_t r;
        r = build_record(ch, exp_seq, ts, pay);
        exp_seq = exp_seq + 1'b1;
        for (int i = 0; i < RECORD_WORDS; i++)
            exp_q.push_back(r[(RECORD_WORDS-1-i)*$bits(word_t) +: $bits(word_t)]);
    endtask

    task automatic write_cmd(input reg_addr_t addr, input cfg_data_t data);
        @(negedge xclk);
        i_cmd_valid = 1'b1;
        i_cmd_addr  = addr;
        i_cmd_data  = data;
        @(negedge xclk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic write_message();
        word_t w;
        for (int i = 0; i < MSG_WORDS; i++) begin
            w = word_t'($urandom);
            write_cmd(reg_addr_t'(ADDR_MSG_BASE + i), {16'h0, w});
            msg_payload[(MSG_WORDS-1-i)*16 +: 16] = w;
        end
    endtask

    task automatic settle(input int n);
        repeat (n) @(negedge xclk);
    endtask

    // trigger on pin, active level is the opposite of idle
    task automatic msg_trigger(input int pin, input logic idle, input int width);
        @(negedge xclk);
        i_gpio[pin] = ~idle;
        push_record(CH_MSG, cyc + TS_LATENCY, msg_payload);
        settle(width);
        i_gpio[pin] = idle;                    // trailing edge makes it ready
    endtask

    task automatic pulse_event(input int width, input logic logged);
        @(negedge xclk);
        i_gpio[PULSE_PIN] = 1'b1;
        if (logged) push_record(CH_PULSE, cyc + DENOISE_CYCLES + TS_LATENCY, 64'h0);
        settle(width);
        i_gpio[PULSE_PIN] = 1'b0;
    endtask

    // message trailing edge lands on the cycle the pulse gets stamped
    task automatic dual_event();
        @(negedge xclk);
        i_gpio[MSG_PIN]   = 1'b1;
        i_gpio[PULSE_PIN] = 1'b1;
        push_record(CH_PULSE, cyc + DENOISE_CYCLES + TS_LATENCY, 64'h0);
        push_record(CH_MSG, cyc + TS_LATENCY, msg_payload);
        settle(DENOISE_CYCLES);
        i_gpio[MSG_PIN] = 1'b0;
        settle(14);
        i_gpio[PULSE_PIN] = 1'b0;
    endtask

    task automatic wait_records(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge xclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected log words never appeared", exp_q.size());
            exp_q.delete();
        end
        settle(24);                            // lets the pulse filter return to low
    endtask

    always @(negedge xclk) begin
        if (rand_ready) i_log_ready = 1'($urandom % 2);
        else i_log_ready = 1'b1;
    end

    // compare each accepted word with the head of the expected queue
    always @(posedge xclk) begin
        if (!config_rst && o_log_valid && i_log_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("log word 0x%0h sent when no record was expected", o_log_data);
            end else begin
                check_value("o_log_data", o_log_data, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(longint'(N_TESTS * CYCLES_PER_TEST + 8) * CLK_PERIOD);
        errors++;
        $display("watchdog expired before the tests finished");
        $display("checks %0d, errors %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        config_rst  = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_addr  = '0;
        i_cmd_data  = '0;
        i_gpio      = '0;
        i_log_ready = 1'b1;
        rand_ready  = 1'b0;
        exp_seq     = '0;
        msg_payload = '0;
        errors      = 0;
        checks      = 0;
        seed_val    = $urandom(64);
        settle(8);
        config_rst = 1'b0;

        // 1: toggling pins log nothing, also with the logger enable off
        for (int i = 0; i < 80; i++) begin
            @(negedge xclk);
            i_gpio = N_GPIO'($urandom);
            check_value("o_log_valid", o_log_valid, 1'b0);
            if (i == 40) write_cmd(ADDR_CONFIG, config_word(4'd3, 1'b0, 1'b1, 4'd5, 1'b1, 1'b0));
        end
        i_gpio = '0;
        settle(24);

        // 2: message on gpio 3
        write_message();
        write_cmd(ADDR_CONFIG, config_word(MSG_PIN, 1'b0, 1'b1, 4'd0, 1'b0, 1'b1));
        settle(4);
        msg_trigger(MSG_PIN, 1'b0, 6);
        wait_records(200);

        // 3: inverted trigger on gpio 7, idle high
        write_message();
        i_gpio[INV_PIN] = 1'b1;
        settle(4);
        write_cmd(ADDR_CONFIG, config_word(INV_PIN, 1'b1, 1'b1, 4'd0, 1'b0, 1'b1));
        settle(4);
        msg_trigger(INV_PIN, 1'b1, 6);
        wait_records(200);

        // 4: short glitch filtered, long pulse logged
        write_cmd(ADDR_CONFIG, config_word(4'd0, 1'b0, 1'b0, PULSE_PIN, 1'b1, 1'b1));
        settle(4);
        pulse_event(DENOISE_CYCLES - 6, 1'b0);
        settle(40);
        pulse_event(30, 1'b1);
        wait_records(200);

        // 5: both channels ready together
        write_message();
        write_cmd(ADDR_CONFIG, config_word(MSG_PIN, 1'b0, 1'b1, PULSE_PIN, 1'b1, 1'b1));
        settle(4);
        dual_event();
        wait_records(300);

        // 6: same traffic under random back-pressure
        rand_ready = 1'b1;
        for (int k = 0; k < 3; k++) begin
            write_message();
            dual_event();
            wait_records(600);
        end
        rand_ready = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/logger_pkg.sv
design/logger_regs_pkg.sv
design/logger_regs.sv
design/msg_channel.sv
design/pulse_channel.sv
design/event_timestamper.sv
design/record_arbiter.sv
design/event_logger.sv
dv/tb_event_logger.sv
